/* list.f */
hw/jalr_pkg.sv
hw/jalr_queue.sv
hw/jalr_target_check.sv
hw/jalr_ctrl.sv
hw/jalr_resolve_top.sv
dv/jalr_resolve_assertions.sv
dv/jalr_resolve_tb.sv

/* dv/jalr_resolve_trace.txt */
# Fields in hex except WAIT cycles, one event per line
# ENQ src_tag base imm pred_target rob_tag | CDB tag value addr_only
# COMMIT target rob_tag mispredict name | WAIT cycles hold_req | END
# Ready at dispatch, odd sum and a negative immediate
ENQ 0 00001000 00000035 00001034 1
COMMIT 00001034 1 0 ready_odd_sum
ENQ 0 00002000 fffffff1 00001ff0 2
COMMIT 00001ff0 2 0 ready_neg_imm
# Waits on tag 5, address-only and foreign broadcasts leave it asleep
ENQ 5 0bad0000 00000011 00004012 3
WAIT 4 1
CDB 5 deadbeef 1
WAIT 3 1
CDB 7 11111111 0
WAIT 2 1
CDB 5 00004001 0
COMMIT 00004012 3 0 cdb_wakeup
# Fill all four slots across the pointer wrap
ENQ 0 00010000 00000100 00010100 4
ENQ 0 00020000 00000203 00020202 5
ENQ 9 00000000 00000040 00030040 6
ENQ 0 7ffffffe 00000003 80000000 7
CDB 9 00030000 0
COMMIT 00010100 4 0 fill_first
ENQ 0 00000500 00000007 00000506 8
COMMIT 00020202 5 0 fill_second
COMMIT 00030040 6 0 fill_woken
COMMIT 80000000 7 0 fill_fourth
COMMIT 00000506 8 0 fill_refilled
# Mispredicted head, three younger jumps get flushed
ENQ 0 00005000 00000020 00005000 9
ENQ 0 00000100 00000100 00000200 a
ENQ c 00000000 00000010 00000010 b
ENQ 0 00000300 00000004 00000304 c
COMMIT 00005020 9 1 mispredict_flush
# Fresh traffic after the flush
ENQ 0 00006000 00000006 00006006 d
ENQ 3 00000000 fffffffc 00007ffc e
CDB 3 00008000 0
COMMIT 00006006 d 0 after_flush_ready
COMMIT 00007ffc e 0 after_flush_woken
END

/* dv/jalr_resolve_tb.sv */
/*
 * JALR resolution testbench
 * Replays a trace of dispatch, CDB and commit events on the DUT,
 * checks every resolved jump and tracks dispatch credits
 */

`timescale 1ns/1ps
`default_nettype none

module jalr_resolve_tb;

    localparam int DEPTH    = 4;
    localparam int CLK_HALF = 20;

    logic               clk;
    logic               reset;
    logic               enq_valid;
    jalr_pkg::rob_tag_t enq_src_tag;
    jalr_pkg::xlen_t    enq_base;
    jalr_pkg::imm_t     enq_imm;
    jalr_pkg::addr_t    enq_pred_target;
    jalr_pkg::rob_tag_t enq_rob_tag;
    logic               cdb_valid;
    jalr_pkg::rob_tag_t cdb_tag;
    jalr_pkg::xlen_t    cdb_value;
    logic               cdb_addr_only;
    logic               commit_req;
    logic               credit_return;
    logic               commit_ack;
    logic               resolve_valid;
    jalr_pkg::addr_t    resolve_target;
    jalr_pkg::rob_tag_t resolve_rob_tag;
    logic               resolve_mispredict;

    string trace_lines[$];
    int    credits;          // Dispatch side credit count
    int    watchdog_cycles;
    bit    trace_done;

    jalr_resolve_top #(
        .DEPTH(DEPTH)
    ) u_dut (
        .clk                (clk),
        .reset              (reset),
        .enq_valid          (enq_valid),
        .enq_src_tag        (enq_src_tag),
        .enq_base           (enq_base),
        .enq_imm            (enq_imm),
        .enq_pred_target    (enq_pred_target),
        .enq_rob_tag        (enq_rob_tag),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value),
        .cdb_addr_only      (cdb_addr_only),
        .commit_req         (commit_req),
        .credit_return      (credit_return),
        .commit_ack         (commit_ack),
        .resolve_valid      (resolve_valid),
        .resolve_target     (resolve_target),
        .resolve_rob_tag    (resolve_rob_tag),
        .resolve_mispredict (resolve_mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_target(input string name, input jalr_pkg::addr_t exp,
                                  input jalr_pkg::addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_tag(input string name, input jalr_pkg::rob_tag_t exp,
                               input jalr_pkg::rob_tag_t act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Drive point a little after the rising edge
    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    // Credits come back on registered pulses and are sampled mid cycle
    always @(negedge clk) begin
        if (!reset && credit_return) begin
            credits = credits + 1;
            if (credits > DEPTH) begin
                fail_run("credit returned while no entry was outstanding");
            end
        end
    end

    // Bound control checker counts its failures
    always @(negedge clk) begin
        if (u_dut.u_ctrl.u_assertions.fail_count != 0) begin
            fail_run("a control timing assertion failed");
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("timeout, the trace did not finish in the allowed number of cycles");
    end

    task automatic load_trace;
        int    fd;
        string line;
        fd = $fopen("dv/jalr_resolve_trace.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the trace file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                trace_lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_commit(input string name, input jalr_pkg::addr_t exp_target,
                              input jalr_pkg::rob_tag_t exp_tag, input logic exp_misp);
        logic ack_seen;
        ack_seen   = 1'b0;
        commit_req = 1'b1;
        while (!ack_seen) begin
            @(negedge clk);
            ack_seen = commit_ack;
            next_cycle();
        end
        commit_req = 1'b0;
        @(negedge clk);
        compare_flag({name, " valid"}, 1'b1, resolve_valid);
        compare_target({name, " target"}, exp_target, resolve_target);
        compare_tag({name, " rob_tag"}, exp_tag, resolve_rob_tag);
        compare_flag({name, " mispredict"}, exp_misp, resolve_mispredict);
        next_cycle();
        // Flush is over once every slot has been handed back
        if (exp_misp) begin
            while (credits != DEPTH) begin
                next_cycle();
            end
        end
    endtask

    task automatic run_line(input string line);
        string       op;
        string       name;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        int          cnt;
        cnt = $sscanf(line, "%s", op);
        case (op)
            "ENQ": begin
                cnt = $sscanf(line, "%s %h %h %h %h %h", op, f1, f2, f3, f4, f5);
                if (cnt != 6) begin
                    fail_run({"malformed ENQ line in the trace: ", line});
                end
                if (credits == 0) begin
                    fail_run("enqueue refused, dispatch holds no credit");
                end
                credits         = credits - 1;
                enq_valid       = 1'b1;
                enq_src_tag     = f1[3:0];
                enq_base        = f2;
                enq_imm         = f3;
                enq_pred_target = f4;
                enq_rob_tag     = f5[3:0];
                next_cycle();
                enq_valid = 1'b0;
            end
            "CDB": begin
                cnt = $sscanf(line, "%s %h %h %h", op, f1, f2, f3);
                if (cnt != 4) begin
                    fail_run({"malformed CDB line in the trace: ", line});
                end
                cdb_valid     = 1'b1;
                cdb_tag       = f1[3:0];
                cdb_value     = f2;
                cdb_addr_only = f3[0];
                next_cycle();
                cdb_valid = 1'b0;
            end
            "COMMIT": begin
                cnt = $sscanf(line, "%s %h %h %h %s", op, f1, f2, f3, name);
                if (cnt != 5) begin
                    fail_run({"malformed COMMIT line in the trace: ", line});
                end
                run_commit(name, f1, f2[3:0], f3[0]);
            end
            "WAIT": begin
                cnt = $sscanf(line, "%s %d %d", op, f1, f2);
                if (cnt != 3) begin
                    fail_run({"malformed WAIT line in the trace: ", line});
                end
                commit_req = f2[0];  // Held request must not be acknowledged
                repeat (f1) begin
                    @(negedge clk);
                    if (f2[0]) begin
                        compare_flag("stalled_commit ack", 1'b0, commit_ack);
                    end
                    next_cycle();
                end
                commit_req = 1'b0;
            end
            "END": trace_done = 1'b1;
            default: fail_run({"unknown opcode in trace line: ", line});
        endcase
    endtask

    initial begin
        reset           = 1'b1;
        enq_valid       = 1'b0;
        enq_src_tag     = '0;
        enq_base        = '0;
        enq_imm         = '0;
        enq_pred_target = '0;
        enq_rob_tag     = '0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        cdb_value       = '0;
        cdb_addr_only   = 1'b0;
        commit_req      = 1'b0;
        credits         = DEPTH;
        watchdog_cycles = 0;
        trace_done      = 1'b0;
        void'($urandom(32'h414c));

        load_trace();
        watchdog_cycles = trace_lines.size() * 40 + 200;

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();

        foreach (trace_lines[i]) begin
            if (!trace_done) begin
                run_line(trace_lines[i]);
                repeat ($urandom % 3) next_cycle();  // Idle gap
            end
        end
        repeat (4) next_cycle();

        if (!trace_done) begin
            fail_run("trace ended without an END line");
        end
        if (credits != DEPTH) begin
            fail_run("dispatch credits were not all returned at the end of the trace");
        end
        if (u_dut.u_ctrl.u_assertions.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_run("control timing assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

/* dv/jalr_resolve_assertions.sv */
/*
 * JALR control checker
 * Timing rules of the commit handshake, the flush FSM and credit returns
 */

`timescale 1ns/1ps
`default_nettype none

module jalr_resolve_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  commit_ack,
    input logic                  resolve_valid,
    input logic                  deq,
    input logic                  flush_step,
    input logic                  credit_return,
    input jalr_pkg::ctrl_state_t state
);

    int fail_count = 0;  // Number of failed timing rules so far

    // Result shows exactly one cycle after the ack
    a_result_after_ack: assert property (@(posedge clk) disable iff (reset)
        commit_ack |=> resolve_valid)
        else begin
            $error("resolve_valid missing one cycle after commit_ack");
            fail_count++;
        end

    a_result_has_ack: assert property (@(posedge clk) disable iff (reset)
        resolve_valid |-> $past(commit_ack))
        else begin
            $error("resolve_valid without a commit_ack in the cycle before");
            fail_count++;
        end

    a_no_ack_in_flush: assert property (@(posedge clk) disable iff (reset)
        (state == jalr_pkg::ST_FLUSH) |-> !commit_ack)
        else begin
            $error("commit_ack while the control FSM is flushing");
            fail_count++;
        end

    // One credit per freed slot, one cycle later
    a_credit_after_pop: assert property (@(posedge clk) disable iff (reset)
        (deq || flush_step) |=> credit_return)
        else begin
            $error("credit_return missing after a freed entry");
            fail_count++;
        end

    a_credit_has_pop: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> $past(deq || flush_step))
        else begin
            $error("credit_return without a freed entry");
            fail_count++;
        end

endmodule

bind jalr_ctrl jalr_resolve_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .commit_ack    (commit_ack),
    .resolve_valid (resolve_valid),
    .deq           (deq),
    .flush_step    (flush_step),
    .credit_return (credit_return),
    .state         (state)
);

`default_nettype wire

/* hw/jalr_resolve_top.sv */
/*
 * JALR resolution top
 * Indirect jump queue, target checker and commit control
 */

`timescale 1ns/1ps
`default_nettype none

module jalr_resolve_top #(
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               enq_valid,
    input  jalr_pkg::rob_tag_t enq_src_tag,
    input  jalr_pkg::xlen_t    enq_base,
    input  jalr_pkg::imm_t     enq_imm,
    input  jalr_pkg::addr_t    enq_pred_target,
    input  jalr_pkg::rob_tag_t enq_rob_tag,
    input  logic               cdb_valid,
    input  jalr_pkg::rob_tag_t cdb_tag,
    input  jalr_pkg::xlen_t    cdb_value,
    input  logic               cdb_addr_only,
    input  logic               commit_req,
    output logic               credit_return,
    output logic               commit_ack,
    output logic               resolve_valid,
    output jalr_pkg::addr_t    resolve_target,
    output jalr_pkg::rob_tag_t resolve_rob_tag,
    output logic               resolve_mispredict
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic               head_ready;
    jalr_pkg::xlen_t    head_base;
    jalr_pkg::imm_t     head_imm;
    jalr_pkg::addr_t    head_pred_target;
    jalr_pkg::rob_tag_t head_rob_tag;
    logic [CNT_W-1:0]   occupied_count;
    logic               deq;
    logic               flush_step;
    logic               capture;
    logic               mispredict_now;

    jalr_queue #(
        .DEPTH(DEPTH)
    ) u_queue (
        .clk              (clk),
        .reset            (reset),
        .enq_valid        (enq_valid),
        .enq_src_tag      (enq_src_tag),
        .enq_base         (enq_base),
        .enq_imm          (enq_imm),
        .enq_pred_target  (enq_pred_target),
        .enq_rob_tag      (enq_rob_tag),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .cdb_addr_only    (cdb_addr_only),
        .deq              (deq),
        .flush_step       (flush_step),
        .head_ready       (head_ready),
        .head_base        (head_base),
        .head_imm         (head_imm),
        .head_pred_target (head_pred_target),
        .head_rob_tag     (head_rob_tag),
        .occupied_count   (occupied_count)
    );

    jalr_target_check u_target_check (
        .clk                (clk),
        .reset              (reset),
        .head_base          (head_base),
        .head_imm           (head_imm),
        .head_pred_target   (head_pred_target),
        .head_rob_tag       (head_rob_tag),
        .capture            (capture),
        .mispredict_now     (mispredict_now),
        .resolve_target     (resolve_target),
        .resolve_rob_tag    (resolve_rob_tag),
        .resolve_mispredict (resolve_mispredict)
    );

    jalr_ctrl #(
        .DEPTH(DEPTH)
    ) u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .commit_req     (commit_req),
        .head_ready     (head_ready),
        .mispredict_now (mispredict_now),
        .occupied_count (occupied_count),
        .commit_ack     (commit_ack),
        .deq            (deq),
        .capture        (capture),
        .flush_step     (flush_step),
        .resolve_valid  (resolve_valid),
        .credit_return  (credit_return)
    );

endmodule

`default_nettype wire

/* hw/jalr_ctrl.sv */
/*
 * JALR control
 * Accepts commit requests for a ready head, times the result valid,
 * walks the queue empty after a mispredict and returns credits
 */

`timescale 1ns/1ps
`default_nettype none

module jalr_ctrl #(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       commit_req,
    input  logic                       head_ready,
    input  logic                       mispredict_now,
    input  logic [$clog2(DEPTH+1)-1:0] occupied_count,
    output logic                       commit_ack,
    output logic                       deq,
    output logic                       capture,
    output logic                       flush_step,
    output logic                       resolve_valid,
    output logic                       credit_return
);

    jalr_pkg::ctrl_state_t state;
    jalr_pkg::ctrl_state_t state_next;

    logic accept;
    logic flush_pending;  // Accepted jump went to the wrong target

    // Commit handshake, only in RUN and only for a ready head
    assign accept        = commit_req && head_ready && (state == jalr_pkg::ST_RUN);
    assign flush_pending = accept && mispredict_now;

    assign commit_ack = accept;
    assign deq        = accept;
    assign capture    = accept;

    // One younger entry dropped per cycle while anything is left
    assign flush_step = (state == jalr_pkg::ST_FLUSH) && (occupied_count != '0);

    always_comb begin
        state_next = state;
        case (state)
            jalr_pkg::ST_RUN: begin
                // FLUSH starts together with resolve_valid
                if (flush_pending) begin
                    state_next = jalr_pkg::ST_FLUSH;
                end
            end
            jalr_pkg::ST_FLUSH: begin
                if (occupied_count == '0) begin
                    state_next = jalr_pkg::ST_RUN;
                end
            end
            default: state_next = jalr_pkg::ST_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= jalr_pkg::ST_RUN;
        end else begin
            state <= state_next;
        end
    end

    // Registered pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_valid <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            resolve_valid <= accept;             // Result shows the cycle after ack
            credit_return <= deq | flush_step;   // Every freed slot gives one credit back
        end
    end

endmodule

`default_nettype wire

/* hw/jalr_target_check.sv */
/*
 * JALR target checker
 * Forms base plus immediate with bit 0 cleared, compares it with the
 * prediction and holds the result of the committed jump
 */

`timescale 1ns/1ps
`default_nettype none

module jalr_target_check (
    input  logic               clk,
    input  logic               reset,
    input  jalr_pkg::xlen_t    head_base,
    input  jalr_pkg::imm_t     head_imm,
    input  jalr_pkg::addr_t    head_pred_target,
    input  jalr_pkg::rob_tag_t head_rob_tag,
    input  logic               capture,
    output logic               mispredict_now,
    output jalr_pkg::addr_t    resolve_target,
    output jalr_pkg::rob_tag_t resolve_rob_tag,
    output logic               resolve_mispredict
);

    jalr_pkg::xlen_t sum;
    jalr_pkg::addr_t target;

    assign sum    = head_base + head_imm;
    assign target = {sum[31:1], 1'b0};  // JALR drops the low bit

    // Compare of whatever sits at the head right now
    assign mispredict_now = (target != head_pred_target);

    // Flag cleared by reset so the output is quiet after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_mispredict <= 1'b0;
        end else if (capture) begin
            resolve_mispredict <= mispredict_now;
        end
    end

    // Result payload, only meaningful with resolve_valid
    always_ff @(posedge clk) begin
        if (capture) begin
            resolve_target  <= target;
            resolve_rob_tag <= head_rob_tag;
        end
    end

endmodule

`default_nettype wire

/* hw/jalr_queue.sv */
/*
 * JALR queue
 * In-order circular buffer of dispatched indirect jumps. Waiting
 * entries snoop the CDB by tag, the head reports when it is ready
 */

`timescale 1ns/1ps
`default_nettype none

module jalr_queue #(
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enq_valid,
    input  jalr_pkg::rob_tag_t         enq_src_tag,
    input  jalr_pkg::xlen_t            enq_base,
    input  jalr_pkg::imm_t             enq_imm,
    input  jalr_pkg::addr_t            enq_pred_target,
    input  jalr_pkg::rob_tag_t         enq_rob_tag,
    input  logic                       cdb_valid,
    input  jalr_pkg::rob_tag_t         cdb_tag,
    input  jalr_pkg::xlen_t            cdb_value,
    input  logic                       cdb_addr_only,
    input  logic                       deq,
    input  logic                       flush_step,
    output logic                       head_ready,
    output jalr_pkg::xlen_t            head_base,
    output jalr_pkg::imm_t             head_imm,
    output jalr_pkg::addr_t            head_pred_target,
    output jalr_pkg::rob_tag_t         head_rob_tag,
    output logic [$clog2(DEPTH+1)-1:0] occupied_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    jalr_pkg::rob_tag_t entry_tag  [DEPTH];  // Source tag, zero once base is known
    jalr_pkg::xlen_t    entry_base [DEPTH];
    jalr_pkg::imm_t     entry_imm  [DEPTH];
    jalr_pkg::addr_t    entry_pred [DEPTH];
    jalr_pkg::rob_tag_t entry_rob  [DEPTH];
    logic [DEPTH-1:0]   entry_valid;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic             cdb_hit;        // Broadcast that carries a register result
    logic             enq_bypass;     // Producer broadcasts in the enqueue cycle

    assign pop        = deq | flush_step;
    assign cdb_hit    = cdb_valid & ~cdb_addr_only;  // Load address step never wakes a jump
    assign enq_bypass = cdb_hit && (enq_src_tag != '0) && (enq_src_tag == cdb_tag);

    // Pointers, count and valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            entry_valid <= '0;
        end else begin
            if (enq_valid) begin
                wr_ptr              <= wr_ptr + 1'b1;  // Power of two depth wraps naturally
                entry_valid[wr_ptr] <= 1'b1;
            end
            if (pop) begin
                rd_ptr              <= rd_ptr + 1'b1;
                entry_valid[rd_ptr] <= 1'b0;
            end
            // No full check, dispatch only sends with a credit in hand
            case ({enq_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload writes and CDB wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (entry_valid[i] && cdb_hit && (entry_tag[i] != '0)
                    && (entry_tag[i] == cdb_tag)) begin
                entry_tag[i]  <= '0;
                entry_base[i] <= cdb_value;
            end
        end
        // The write slot is free, so it never collides with a wakeup above
        if (enq_valid) begin
            entry_tag[wr_ptr]  <= enq_bypass ? '0 : enq_src_tag;
            entry_base[wr_ptr] <= enq_bypass ? cdb_value : enq_base;
            entry_imm[wr_ptr]  <= enq_imm;
            entry_pred[wr_ptr] <= enq_pred_target;
            entry_rob[wr_ptr]  <= enq_rob_tag;
        end
    end

    // Head view
    assign head_ready       = entry_valid[rd_ptr] && (entry_tag[rd_ptr] == '0);
    assign head_base        = entry_base[rd_ptr];
    assign head_imm         = entry_imm[rd_ptr];
    assign head_pred_target = entry_pred[rd_ptr];
    assign head_rob_tag     = entry_rob[rd_ptr];
    assign occupied_count   = count;

endmodule

`default_nettype wire

/* hw/jalr_pkg.sv */
/*
 * JALR resolution package
 * Tag, data word, address and immediate types shared by the
 * indirect jump queue, the target checker and the control FSM
 */

`default_nettype none

package jalr_pkg;

    // Reorder buffer tag width, tag zero means no pending producer
    localparam int ROB_TAG_W = 4;
    localparam int XLEN      = 32;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Register values, both base operands and CDB results
    typedef logic [XLEN-1:0] xlen_t;

    // Instruction addresses, predicted and resolved targets
    typedef logic [XLEN-1:0] addr_t;

    // Sign extended by decode before it reaches the queue
    typedef logic [XLEN-1:0] imm_t;

    // Commit FSM
    typedef enum logic {
        ST_RUN   = 1'b0,  // Normal commit
        ST_FLUSH = 1'b1   // Dropping younger jumps after a mispredict
    } ctrl_state_t;

endpackage

`default_nettype wire
